/* logic/lsuPkg.sv */
/*
 * Shared widths, address fields and encodings of the data cache.
 * Direct mapped, 16 lines of 8 bytes, 16-bit physical addresses.
 * Address layout is tag [15:7], index [6:3], offset [2:0].
 */
package lsuPkg;

    localparam int lineSize = 8;
    localparam int indexWidth = 4;
    localparam int paddrWidth = 16;
    localparam int offsetWidth = 3;
    localparam int tagWidth = paddrWidth - indexWidth - offsetWidth;

    typedef logic [paddrWidth-1:0] paddr_t;
    typedef logic [paddrWidth-offsetWidth-1:0] lineAddr_t;
    typedef logic [indexWidth-1:0] index_t;
    typedef logic [tagWidth-1:0] tag_t;
    typedef logic [offsetWidth-1:0] offset_t;
    typedef logic [8*lineSize-1:0] line_t;
    typedef logic [lineSize-1:0] writeMask_t;
    typedef logic [63:0] dword_t;
    typedef logic [31:0] word_t;

    // Stores here also update hostIoValue
    localparam paddr_t hostIoAddr = 16'hFFF0;

    typedef enum logic [1:0] {
        CmdNone,
        CmdLoad,
        CmdStore,
        CmdInvalidate
    } LsuCommand;

    typedef enum logic [2:0] {
        SizeByte,
        SizeHalf,
        SizeWord,
        SizeDouble,
        SizeUByte,
        SizeUHalf,
        SizeUWord
    } LoadStoreType;

    typedef enum logic [2:0] {
        StateIdle,
        StateLoad,
        StateStore,
        StateRefill,
        StateWriteThrough,
        StateInvalidate
    } LsuState;

    typedef enum logic [1:0] {
        OpNone,
        OpRefill,
        OpWriteThrough,
        OpInvalidate
    } TransferOp;

endpackage

/* logic/dcacheArrays.sv */
/*
 * Tag and data arrays of the direct-mapped cache.
 * Reads are registered and read-first: a write is seen by the read
 * at the following edge, not the same one.
 * Only the valid bits are cleared by reset.
 */
`timescale 1ns/1ps

module dcacheArrays import lsuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  index_t     index,
    input  logic       tagWriteEnable,
    input  logic       tagWriteValid,
    input  tag_t       tagWriteTag,
    input  writeMask_t dataWriteMask,
    input  line_t      dataWriteValue,
    output logic       readValid,
    output tag_t       readTag,
    output line_t      readData
);

    logic [2**indexWidth-1:0] validBits;
    tag_t tagArray [2**indexWidth];
    line_t dataArray [2**indexWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            if (tagWriteEnable) begin
                validBits[index] <= tagWriteValid;
            end
            readValid <= validBits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (tagWriteEnable) begin
            tagArray[index] <= tagWriteTag;
        end
        readTag <= tagArray[index];
    end

    // One write lane per byte
    always_ff @(posedge clk) begin
        for (int i = 0; i < lineSize; i++) begin
            if (dataWriteMask[i]) begin
                dataArray[index][8*i +: 8] <= dataWriteValue[8*i +: 8];
            end
        end
        readData <= dataArray[index];
    end

endmodule

/* logic/lineTransfer.sv */
/*
 * Whole-line moves between the cache arrays and memory.
 * op must be held until transferDone. Requests stay high up to and
 * including the grant cycle.
 * A write-through waits one cycle so the array read returns the
 * line as just updated by the store.
 */
`timescale 1ns/1ps

module lineTransfer import lsuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  TransferOp op,
    input  lineAddr_t lineAddr,
    input  line_t     arrayData,
    input  logic      memReadGrant,
    input  logic      memWriteGrant,
    input  line_t     memReadValue,
    output lineAddr_t memAddr,
    output logic      memReadReq,
    output logic      memWriteReq,
    output line_t     memWriteValue,
    output index_t    arrayIndex,
    output logic      arrayWriteEnable,
    output logic      arrayWriteValid,
    output tag_t      arrayWriteTag,
    output line_t     arrayWriteData,
    output logic      transferDone
);

    index_t sweepIndex;
    logic lineReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIndex <= '0;
            lineReady <= 1'b0;
        end else begin
            sweepIndex <= (op == OpInvalidate) ? sweepIndex + 1'b1 : '0;
            lineReady <= (op == OpWriteThrough) && !memWriteGrant;
        end
    end

    assign memAddr = lineAddr;
    assign memReadReq = (op == OpRefill);
    assign memWriteReq = (op == OpWriteThrough) && lineReady;
    assign memWriteValue = arrayData;

    assign arrayIndex = (op == OpInvalidate) ? sweepIndex : lineAddr[indexWidth-1:0];
    assign arrayWriteEnable = ((op == OpRefill) && memReadGrant) || (op == OpInvalidate);
    assign arrayWriteValid = (op == OpRefill);
    assign arrayWriteTag = lineAddr[$bits(lineAddr_t)-1:indexWidth];
    assign arrayWriteData = memReadValue;

    always_comb begin
        case (op)
            OpRefill:       transferDone = memReadGrant;
            OpWriteThrough: transferDone = memWriteGrant;
            // Last index of the sweep
            OpInvalidate:   transferDone = (sweepIndex == '1);
            default:        transferDone = 1'b0;
        endcase
    end

endmodule

/* logic/loadStoreAlign.sv */
/*
 * Byte alignment between cache lines and 64-bit load/store values.
 * Accesses are assumed naturally aligned; bytes past the end of the
 * line read as zero and are never written.
 */
`timescale 1ns/1ps

module loadStoreAlign import lsuPkg::*; (
    input  line_t        lineData,
    input  offset_t      offset,
    input  LoadStoreType size,
    input  dword_t       storeValue,
    output dword_t       loadValue,
    output line_t        storeLine,
    output writeMask_t   storeMask
);

    dword_t shifted;
    logic [5:0] bitShift;

    assign bitShift = {offset, 3'b000};
    assign shifted = lineData >> bitShift;

    always_comb begin
        case (size)
            SizeByte:  loadValue = {{56{shifted[7]}}, shifted[7:0]};
            SizeHalf:  loadValue = {{48{shifted[15]}}, shifted[15:0]};
            SizeWord:  loadValue = {{32{shifted[31]}}, shifted[31:0]};
            SizeUByte: loadValue = {56'b0, shifted[7:0]};
            SizeUHalf: loadValue = {48'b0, shifted[15:0]};
            SizeUWord: loadValue = {32'b0, shifted[31:0]};
            default:   loadValue = shifted;
        endcase
    end

    assign storeLine = storeValue << bitShift;

    always_comb begin
        case (size)
            SizeByte, SizeUByte: storeMask = 8'b0000_0001 << offset;
            SizeHalf, SizeUHalf: storeMask = 8'b0000_0011 << offset;
            SizeWord, SizeUWord: storeMask = 8'b0000_1111 << offset;
            default:             storeMask = 8'b1111_1111 << offset;
        endcase
    end

endmodule

/* logic/loadStoreControl.sv */
/*
 * Main FSM of the load/store unit.
 * The request is sampled in Idle and must stay stable until done.
 * A miss refills the line and returns to Idle for a fresh lookup.
 * Only one request is handled at a time.
 */
`timescale 1ns/1ps

module loadStoreControl import lsuPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         enable,
    input  LsuCommand    command,
    input  paddr_t       addr,
    input  LoadStoreType loadStoreType,
    input  dword_t       storeValue,
    input  logic         readValid,
    input  tag_t         readTag,
    input  dword_t       loadValue,
    input  line_t        storeLine,
    input  writeMask_t   storeMask,
    input  logic         transferDone,
    output logic         done,
    output dword_t       result,
    output offset_t      regOffset,
    output LoadStoreType regSize,
    output dword_t       regStoreValue,
    output index_t       index,
    output writeMask_t   dataWriteMask,
    output line_t        dataWriteValue,
    output TransferOp    transferOp,
    output lineAddr_t    lineAddr,
    output logic         arraySel,
    output word_t        hostIoValue
);

    LsuState state;
    LsuState nextState;
    paddr_t regAddr;
    logic hit;

    assign hit = readValid && (readTag == regAddr[paddrWidth-1 -: tagWidth]);

    always_comb begin
        nextState = state;
        case (state)
            StateIdle: begin
                if (enable) begin
                    case (command)
                        CmdLoad:       nextState = StateLoad;
                        CmdStore:      nextState = StateStore;
                        CmdInvalidate: nextState = StateInvalidate;
                        default:       nextState = StateIdle;
                    endcase
                end
            end
            StateLoad:  nextState = hit ? StateIdle : StateRefill;
            StateStore: nextState = hit ? StateWriteThrough : StateRefill;
            StateRefill, StateWriteThrough, StateInvalidate: begin
                if (transferDone) begin
                    nextState = StateIdle;
                end
            end
            default: nextState = StateIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            hostIoValue <= '0;
        end else begin
            state <= nextState;
            if (state == StateWriteThrough && transferDone && regAddr == hostIoAddr) begin
                hostIoValue <= regStoreValue[31:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle && enable) begin
            regAddr <= addr;
            regSize <= loadStoreType;
            regStoreValue <= storeValue;
        end
    end

    // A request with no command completes at once
    assign done = (state == StateIdle && enable && command == CmdNone) ||
                  (state == StateLoad && hit) ||
                  ((state == StateWriteThrough || state == StateInvalidate) && transferDone);
    assign result = loadValue;

    assign regOffset = regAddr[offsetWidth-1:0];
    assign lineAddr = regAddr[paddrWidth-1:offsetWidth];

    // Idle looks up the incoming address so a hit completes in one cycle
    assign index = (state == StateIdle) ? addr[offsetWidth +: indexWidth]
                                        : regAddr[offsetWidth +: indexWidth];
    assign dataWriteMask = (state == StateStore && hit) ? storeMask : '0;
    assign dataWriteValue = storeLine;

    assign arraySel = (state == StateRefill) || (state == StateInvalidate);

    always_comb begin
        case (state)
            StateRefill:       transferOp = OpRefill;
            StateWriteThrough: transferOp = OpWriteThrough;
            StateInvalidate:   transferOp = OpInvalidate;
            default:           transferOp = OpNone;
        endcase
    end

endmodule

/* logic/loadStoreUnit.sv */
/*
 * Write-through data cache with load/store control.
 * Request inputs are held from enable until done; done is a pulse.
 * Memory requests are levels held until their one-cycle grant.
 * Addresses are physical; accesses must be naturally aligned.
 */
`timescale 1ns/1ps

module loadStoreUnit import lsuPkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         enable,
    input  LsuCommand    command,
    input  paddr_t       addr,
    input  LoadStoreType loadStoreType,
    input  dword_t       storeValue,
    output logic         done,
    output dword_t       result,
    output lineAddr_t    memAddr,
    output logic         memReadReq,
    output logic         memWriteReq,
    output line_t        memWriteValue,
    input  logic         memReadGrant,
    input  logic         memWriteGrant,
    input  line_t        memReadValue,
    output word_t        hostIoValue
);

    logic readValid;
    tag_t readTag;
    line_t readData;

    offset_t regOffset;
    LoadStoreType regSize;
    dword_t regStoreValue;
    dword_t loadValue;
    line_t storeLine;
    writeMask_t storeMask;

    index_t ctrlIndex;
    writeMask_t ctrlWriteMask;
    line_t ctrlWriteValue;
    TransferOp transferOp;
    lineAddr_t lineAddr;
    logic arraySel;
    logic transferDone;

    index_t xferIndex;
    logic xferWriteEnable;
    logic xferWriteValid;
    tag_t xferWriteTag;
    line_t xferWriteData;

    index_t arrayIndex;
    writeMask_t arrayWriteMask;
    line_t arrayWriteValue;

    // Array port owner, chosen by the control
    assign arrayIndex = arraySel ? xferIndex : ctrlIndex;
    assign arrayWriteMask = arraySel ? {lineSize{xferWriteEnable & xferWriteValid}}
                                     : ctrlWriteMask;
    assign arrayWriteValue = arraySel ? xferWriteData : ctrlWriteValue;

    dcacheArrays arrays (
        .clk            (clk),
        .rst            (rst),
        .index          (arrayIndex),
        .tagWriteEnable (xferWriteEnable),
        .tagWriteValid  (xferWriteValid),
        .tagWriteTag    (xferWriteTag),
        .dataWriteMask  (arrayWriteMask),
        .dataWriteValue (arrayWriteValue),
        .readValid      (readValid),
        .readTag        (readTag),
        .readData       (readData)
    );

    lineTransfer transfer (
        .clk              (clk),
        .rst              (rst),
        .op               (transferOp),
        .lineAddr         (lineAddr),
        .arrayData        (readData),
        .memReadGrant     (memReadGrant),
        .memWriteGrant    (memWriteGrant),
        .memReadValue     (memReadValue),
        .memAddr          (memAddr),
        .memReadReq       (memReadReq),
        .memWriteReq      (memWriteReq),
        .memWriteValue    (memWriteValue),
        .arrayIndex       (xferIndex),
        .arrayWriteEnable (xferWriteEnable),
        .arrayWriteValid  (xferWriteValid),
        .arrayWriteTag    (xferWriteTag),
        .arrayWriteData   (xferWriteData),
        .transferDone     (transferDone)
    );

    loadStoreAlign align (
        .lineData   (readData),
        .offset     (regOffset),
        .size       (regSize),
        .storeValue (regStoreValue),
        .loadValue  (loadValue),
        .storeLine  (storeLine),
        .storeMask  (storeMask)
    );

    loadStoreControl control (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .command        (command),
        .addr           (addr),
        .loadStoreType  (loadStoreType),
        .storeValue     (storeValue),
        .readValid      (readValid),
        .readTag        (readTag),
        .loadValue      (loadValue),
        .storeLine      (storeLine),
        .storeMask      (storeMask),
        .transferDone   (transferDone),
        .done           (done),
        .result         (result),
        .regOffset      (regOffset),
        .regSize        (regSize),
        .regStoreValue  (regStoreValue),
        .index          (ctrlIndex),
        .dataWriteMask  (ctrlWriteMask),
        .dataWriteValue (ctrlWriteValue),
        .transferOp     (transferOp),
        .lineAddr       (lineAddr),
        .arraySel       (arraySel),
        .hostIoValue    (hostIoValue)
    );

endmodule

/* verif/memoryModel.sv */
/*
 * Behavioral line memory for the load/store unit testbench.
 * Holds every line of the 16-bit address space. Byte a starts as
 * a[7:0] ^ a[15:8] ^ 8'h5A and is refilled while rst is high.
 * Grants come 1 to 4 cycles after a request, one request at a time.
 * Outputs change on the falling clock edge.
 */
`timescale 1ns/1ps

module memoryModel import lsuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  lineAddr_t memAddr,
    input  logic      memReadReq,
    input  logic      memWriteReq,
    input  line_t     memWriteValue,
    output logic      memReadGrant,
    output logic      memWriteGrant,
    output line_t     memReadValue
);

    localparam int lineCount = 8192;

    line_t lines [lineCount];
    logic [31:0] lcgState;
    logic [1:0] delay;
    logic [1:0] waited;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic line_t fillLine(input int lineNum);
        line_t data;
        paddr_t a;
        for (int b = 0; b < lineSize; b++) begin
            a = paddr_t'(lineNum * lineSize + b);
            data[8*b +: 8] = a[7:0] ^ a[15:8] ^ 8'h5A;
        end
        return data;
    endfunction

    // Extra wait before the next grant, 0 to 3 cycles
    assign delay = lcgState[17:16];

    always @(negedge clk) begin
        if (rst) begin
            memReadGrant <= 1'b0;
            memWriteGrant <= 1'b0;
            memReadValue <= '0;
            waited <= '0;
            lcgState <= 32'h9790;
            for (int l = 0; l < lineCount; l++) begin
                lines[13'(l)] <= fillLine(l);
            end
        end else if (memReadGrant || memWriteGrant) begin
            // Request drops at the edge that sees the grant
            memReadGrant <= 1'b0;
            memWriteGrant <= 1'b0;
            waited <= '0;
            lcgState <= lcgNext(lcgState);
        end else if (memReadReq || memWriteReq) begin
            if (waited == delay) begin
                if (memReadReq) begin
                    memReadValue <= lines[memAddr];
                    memReadGrant <= 1'b1;
                end else begin
                    lines[memAddr] <= memWriteValue;
                    memWriteGrant <= 1'b1;
                end
            end else begin
                waited <= waited + 2'd1;
            end
        end
    end

endmodule

/* verif/tbLoadStoreUnit.sv */
/*
 * Testbench of the load/store unit.
 * Applies a table of requests on falling edges, holding enable until
 * done, and checks results against a byte-level reference memory.
 * Only naturally aligned accesses are used.
 */
`timescale 1ns/1ps

module tbLoadStoreUnit import lsuPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int cyclesPerEntry = 200;

    typedef struct packed {
        LsuCommand    cmd;
        paddr_t       address;
        LoadStoreType size;
        dword_t       value;
        logic [7:0]   latency;
    } Request;

    logic clk;
    logic rst;
    logic enable;
    LsuCommand command;
    paddr_t addr;
    LoadStoreType loadStoreType;
    dword_t storeValue;
    logic done;
    dword_t result;
    lineAddr_t memAddr;
    logic memReadReq;
    logic memWriteReq;
    line_t memWriteValue;
    logic memReadGrant;
    logic memWriteGrant;
    line_t memReadValue;
    word_t hostIoValue;

    Request requests[$];
    logic [7:0] refMem [65536];
    word_t hostExpected;
    int errorCount;
    bit tableReady;

    loadStoreUnit DUT (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .command       (command),
        .addr          (addr),
        .loadStoreType (loadStoreType),
        .storeValue    (storeValue),
        .done          (done),
        .result        (result),
        .memAddr       (memAddr),
        .memReadReq    (memReadReq),
        .memWriteReq   (memWriteReq),
        .memWriteValue (memWriteValue),
        .memReadGrant  (memReadGrant),
        .memWriteGrant (memWriteGrant),
        .memReadValue  (memReadValue),
        .hostIoValue   (hostIoValue)
    );

    memoryModel memory (
        .clk           (clk),
        .rst           (rst),
        .memAddr       (memAddr),
        .memReadReq    (memReadReq),
        .memWriteReq   (memWriteReq),
        .memWriteValue (memWriteValue),
        .memReadGrant  (memReadGrant),
        .memWriteGrant (memWriteGrant),
        .memReadValue  (memReadValue)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL at %0t ns: %s got %h, expected %h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic addRequest(input LsuCommand cmd, input paddr_t a, input LoadStoreType size,
                              input dword_t value, input int latency);
        Request r;
        r.cmd = cmd;
        r.address = a;
        r.size = size;
        r.value = value;
        r.latency = 8'(latency);
        requests.push_back(r);
    endtask

    function automatic int byteCount(input LoadStoreType size);
        case (size)
            SizeByte, SizeUByte: return 1;
            SizeHalf, SizeUHalf: return 2;
            SizeWord, SizeUWord: return 4;
            default:             return 8;
        endcase
    endfunction

    // Little endian gather, then sign extension by arithmetic shift
    function automatic dword_t expectedLoad(input paddr_t a, input LoadStoreType size);
        dword_t raw;
        logic signed [63:0] aligned;
        paddr_t byteAddr;
        int n;
        raw = '0;
        n = byteCount(size);
        for (int i = 0; i < n; i++) begin
            byteAddr = a + paddr_t'(i);
            raw[8*i +: 8] = refMem[byteAddr];
        end
        if (size == SizeByte || size == SizeHalf || size == SizeWord) begin
            aligned = $signed(raw << (64 - 8 * n));
            return dword_t'(aligned >>> (64 - 8 * n));
        end
        return raw;
    endfunction

    task automatic applyStore(input paddr_t a, input LoadStoreType size, input dword_t value);
        paddr_t byteAddr;
        for (int i = 0; i < byteCount(size); i++) begin
            byteAddr = a + paddr_t'(i);
            refMem[byteAddr] = value[8*i +: 8];
        end
        if (a == 16'hFFF0) begin
            hostExpected = value[31:0];
        end
    endtask

    task automatic buildTable();
        // Tag 1 line, every byte negative
        addRequest(CmdLoad, 16'h00C0, SizeDouble, 64'h0, 0);
        addRequest(CmdLoad, 16'h00C3, SizeByte, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C5, SizeUByte, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C6, SizeHalf, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C2, SizeUHalf, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C4, SizeWord, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C0, SizeUWord, 64'h0, 1);
        // Same index, other tags
        addRequest(CmdLoad, 16'h0041, SizeByte, 64'h0, 0);
        addRequest(CmdLoad, 16'h0044, SizeWord, 64'h0, 1);
        addRequest(CmdLoad, 16'h0046, SizeHalf, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C0, SizeDouble, 64'h0, 0);
        addRequest(CmdLoad, 16'h1244, SizeUWord, 64'h0, 0);
        addRequest(CmdLoad, 16'h0040, SizeDouble, 64'h0, 0);
        // Stores with neighbors read back
        addRequest(CmdStore, 16'h0203, SizeByte, 64'h1111_2222_3333_44A5, 0);
        addRequest(CmdLoad, 16'h0200, SizeDouble, 64'h0, 1);
        addRequest(CmdStore, 16'h0206, SizeHalf, 64'h0000_0000_0000_BEEF, 0);
        addRequest(CmdLoad, 16'h0206, SizeUHalf, 64'h0, 1);
        addRequest(CmdLoad, 16'h0200, SizeDouble, 64'h0, 1);
        addRequest(CmdStore, 16'h0310, SizeDouble, 64'h0123_4567_89AB_CDEF, 0);
        addRequest(CmdLoad, 16'h0310, SizeDouble, 64'h0, 1);
        addRequest(CmdStore, 16'h0314, SizeWord, 64'hFFFF_FFFF_8765_4321, 0);
        addRequest(CmdLoad, 16'h0314, SizeWord, 64'h0, 1);
        addRequest(CmdLoad, 16'h0310, SizeDouble, 64'h0, 1);
        // After invalidate the data must come back from memory
        addRequest(CmdInvalidate, 16'h0000, SizeDouble, 64'h0, 16);
        addRequest(CmdLoad, 16'h0200, SizeDouble, 64'h0, 0);
        addRequest(CmdLoad, 16'h0310, SizeDouble, 64'h0, 0);
        addRequest(CmdLoad, 16'h0206, SizeHalf, 64'h0, 1);
        addRequest(CmdLoad, 16'h00C3, SizeByte, 64'h0, 0);
        // Host I/O word
        addRequest(CmdStore, 16'hFFF0, SizeWord, 64'h1122_3344_CAFE_F00D, 0);
        addRequest(CmdLoad, 16'hFFF0, SizeWord, 64'h0, 1);
        addRequest(CmdStore, 16'hFFF0, SizeUWord, 64'h0000_0000_1357_9BDF, 0);
        addRequest(CmdInvalidate, 16'h0000, SizeDouble, 64'h0, 16);
        addRequest(CmdLoad, 16'hFFF0, SizeUWord, 64'h0, 0);
    endtask

    initial begin
        Request req;
        paddr_t a;
        int cycles;
        rst = 1'b1;
        enable = 1'b0;
        command = CmdNone;
        addr = '0;
        loadStoreType = SizeDouble;
        storeValue = '0;
        errorCount = 0;
        hostExpected = '0;
        for (int i = 0; i < 65536; i++) begin
            a = paddr_t'(i);
            refMem[a] = a[7:0] ^ a[15:8] ^ 8'h5A;
        end
        buildTable();
        tableReady = 1'b1;

        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkEqual(64'(hostIoValue), 64'h0, "hostIoValue after reset");

        foreach (requests[k]) begin
            req = requests[k];
            enable = 1'b1;
            command = req.cmd;
            addr = req.address;
            loadStoreType = req.size;
            storeValue = req.value;
            cycles = 0;
            // Edge that takes the request, then count edges until done
            @(posedge clk);
            do begin
                @(posedge clk);
                cycles++;
            end while (!done);
            if (req.latency != 0) begin
                checkEqual(64'(cycles), 64'(req.latency),
                           $sformatf("entry %0d cycles to done", k));
            end else if (req.cmd == CmdLoad) begin
                // A load without a fixed latency misses and must refill
                checkEqual(64'(cycles > 1), 64'h1,
                           $sformatf("entry %0d miss took more than one cycle", k));
            end
            if (req.cmd == CmdLoad) begin
                checkEqual(result, expectedLoad(req.address, req.size),
                           $sformatf("entry %0d load at %h", k, req.address));
            end else if (req.cmd == CmdStore) begin
                applyStore(req.address, req.size, req.value);
            end
            @(negedge clk);
            enable = 1'b0;
            command = CmdNone;
            // One idle cycle before the next request
            @(negedge clk);
            checkEqual(64'(hostIoValue), 64'(hostExpected),
                       $sformatf("entry %0d hostIoValue", k));
        end

        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (tableReady);
        repeat (requests.size() * cyclesPerEntry + 10) @(posedge clk);
        $display("Timeout: the DUT did not complete the request table in time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* flist.f */
logic/lsuPkg.sv
logic/dcacheArrays.sv
logic/lineTransfer.sv
logic/loadStoreAlign.sv
logic/loadStoreControl.sv
logic/loadStoreUnit.sv
verif/memoryModel.sv
verif/tbLoadStoreUnit.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tbLoadStoreUnit -f flist.f -o simLoadStoreUnit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/simLoadStoreUnit 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
